// File: rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// ====================
	// Bus widths and address map
	// ====================

	localparam int DATA_W = 32;

	// Region field is the top bits of the address
	localparam int REGION_W = 4;

	localparam logic [REGION_W-1:0] REGION_RAM   = 4'h1;
	localparam logic [REGION_W-1:0] REGION_LED   = 4'h4;
	localparam logic [REGION_W-1:0] REGION_TIMER = 4'hA;

	// ====================
	// Target sizes
	// ====================

	localparam int RAM_WORDS = 1024;
	// Word index starts at address bit 2
	localparam int RAM_AW    = 10;

	localparam int LED_W = 10;

	// Timer register select is address bit 2
	localparam logic TIMER_REG_COUNT   = 1'b0;
	localparam logic TIMER_REG_COMPARE = 1'b1;

	// ====================
	// Timing
	// ====================

	// Clock cycles between key samples
	localparam int KEY_TICK = 16;

	// Strobe to ready, one cycle per stage
	localparam int BUS_LATENCY = 3;

	typedef enum logic [1:0] {
		TARGET_RAM,
		TARGET_LED,
		TARGET_TIMER,
		TARGET_NONE
	} target_t;

endpackage

`default_nettype wire

// File: rtl/key_reset_sequencer.sv
`default_nettype none

module key_reset_sequencer
	import soc_pkg::*;
(
	input  wire logic clock,
	input  wire logic i_rst,
	input  wire logic i_key,
	output logic      o_soft_rst
);

	localparam int TICK_W = $clog2(KEY_TICK);

	logic [TICK_W-1:0] tick_count;
	logic              tick;
	logic [2:0]        history;
	logic [2:0]        history_next;

	// Sample strobe once per KEY_TICK cycles
	assign tick = (tick_count == TICK_W'(KEY_TICK - 1));

	// Key is low while pressed, so two low samples then a high one is a release
	assign history_next = {history[1:0], i_key};

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			tick_count <= '0;
			history    <= 3'b111;
			o_soft_rst <= 1'b0;
		end
		else
		begin
			tick_count <= tick ? '0 : tick_count + 1'b1;
			o_soft_rst <= 1'b0;
			if (tick)
			begin
				history    <= history_next;
				o_soft_rst <= (history_next == 3'b001);
			end
		end
	end

	// Pulse stays one cycle wide, samples are KEY_TICK apart
	a_soft_rst_single: assert property (@(posedge clock) disable iff (i_rst)
		o_soft_rst |=> !o_soft_rst);

endmodule

`default_nettype wire

// File: rtl/bus_decode_stage.sv
`default_nettype none

module bus_decode_stage
	import soc_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              i_rst,
	input  wire logic              i_req,
	input  wire logic              i_rw,
	input  wire logic [DATA_W-1:0] i_addr,
	input  wire logic [DATA_W-1:0] i_wdata,
	output logic                   o_req_valid,
	output target_t                o_req_target,
	output logic                   o_req_rw,
	output logic [DATA_W-1:0]      o_req_addr,
	output logic [DATA_W-1:0]      o_req_wdata
);

	logic [REGION_W-1:0] region;
	target_t             target;

	assign region = i_addr[DATA_W-1 -: REGION_W];

	// ====================
	// Region decode
	// ====================

	always_comb
	begin
		case (region)
			REGION_RAM:   target = TARGET_RAM;
			REGION_LED:   target = TARGET_LED;
			REGION_TIMER: target = TARGET_TIMER;
			// Anything else gets the error response
			default:      target = TARGET_NONE;
		endcase
	end

	// Strobe register
	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			o_req_valid <= 1'b0;
		end
		else
		begin
			o_req_valid <= i_req;
		end
	end

	// Request fields follow the bus every cycle
	always_ff @(posedge clock)
	begin
		o_req_target <= target;
		o_req_rw     <= i_rw;
		o_req_addr   <= i_addr;
		o_req_wdata  <= i_wdata;
	end

	// Both targets and the response stage steer on this field
	a_target_known: assert property (@(posedge clock) disable iff (i_rst)
		o_req_valid |-> !$isunknown(o_req_target));

endmodule

`default_nettype wire

// File: rtl/block_ram.sv
`default_nettype none

module block_ram
	import soc_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              i_rst,
	input  wire logic              i_req_valid,
	input  wire target_t           i_req_target,
	input  wire logic              i_req_rw,
	input  wire logic [DATA_W-1:0] i_req_addr,
	input  wire logic [DATA_W-1:0] i_req_wdata,
	output logic                   o_ack,
	output logic [DATA_W-1:0]      o_rdata
);

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0] index;
	logic              sel;

	assign sel   = i_req_valid && (i_req_target == TARGET_RAM);
	assign index = i_req_addr[RAM_AW+1:2];

	// Power-up contents, loaded into the block RAM at configuration
	initial
	begin
		for (int i = 0; i < RAM_WORDS; i++)
			mem[i] = '0;
	end

	// Single port, write returns zero data
	always_ff @(posedge clock)
	begin
		if (sel)
		begin
			if (i_req_rw)
			begin
				mem[index] <= i_req_wdata;
				o_rdata    <= '0;
			end
			else
			begin
				o_rdata <= mem[index];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_rst)
			o_ack <= 1'b0;
		else
			o_ack <= sel;
	end

endmodule

`default_nettype wire

// File: rtl/led_timer_stage.sv
`default_nettype none

module led_timer_stage
	import soc_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              i_rst,
	input  wire logic              i_req_valid,
	input  wire target_t           i_req_target,
	input  wire logic              i_req_rw,
	input  wire logic [DATA_W-1:0] i_req_addr,
	input  wire logic [DATA_W-1:0] i_req_wdata,
	output logic                   o_ack,
	output logic [DATA_W-1:0]      o_rdata,
	output logic [LED_W-1:0]       o_led,
	output logic                   o_timer_irq
);

	logic              sel_led;
	logic              sel_timer;
	logic              reg_sel;
	logic              count_wr;
	logic              compare_wr;
	logic [DATA_W-1:0] counter;
	logic [DATA_W-1:0] compare;

	assign sel_led   = i_req_valid && (i_req_target == TARGET_LED);
	assign sel_timer = i_req_valid && (i_req_target == TARGET_TIMER);
	assign reg_sel   = i_req_addr[2];

	assign count_wr   = sel_timer && i_req_rw && (reg_sel == TIMER_REG_COUNT);
	assign compare_wr = sel_timer && i_req_rw && (reg_sel == TIMER_REG_COMPARE);

	// ====================
	// LED register
	// ====================

	always_ff @(posedge clock)
	begin
		if (i_rst)
			o_led <= '0;
		else if (sel_led && i_req_rw)
			o_led <= i_req_wdata[LED_W-1:0];
	end

	// ====================
	// Timer
	// ====================

	// Free-running, a bus write loads it instead of the increment
	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			counter <= '0;
			compare <= '1;
		end
		else
		begin
			counter <= count_wr ? i_req_wdata : counter + 1'b1;
			if (compare_wr)
				compare <= i_req_wdata;
		end
	end

	// Level interrupt, drops as soon as compare moves above the count
	assign o_timer_irq = (counter >= compare);

	// Read path, LED is write-only and reads as zero
	always_ff @(posedge clock)
	begin
		if (sel_timer && !i_req_rw)
			o_rdata <= (reg_sel == TIMER_REG_COMPARE) ? compare : counter;
		else
			o_rdata <= '0;
	end

	always_ff @(posedge clock)
	begin
		if (i_rst)
			o_ack <= 1'b0;
		else
			o_ack <= sel_led || sel_timer;
	end

	a_ack_follows_req: assert property (@(posedge clock) disable iff (i_rst)
		o_ack |-> $past(i_req_valid));

endmodule

`default_nettype wire

// File: rtl/response_stage.sv
`default_nettype none

module response_stage
	import soc_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              i_rst,
	input  wire logic              i_req_valid,
	input  wire target_t           i_req_target,
	input  wire logic              i_ram_ack,
	input  wire logic [DATA_W-1:0] i_ram_rdata,
	input  wire logic              i_periph_ack,
	input  wire logic [DATA_W-1:0] i_periph_rdata,
	output logic                   o_ready,
	output logic [DATA_W-1:0]      o_rdata,
	output logic                   o_bus_err
);

	// Unmapped access, held one cycle to match the target latency
	logic none_ack;

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			none_ack  <= 1'b0;
			o_ready   <= 1'b0;
			o_bus_err <= 1'b0;
		end
		else
		begin
			none_ack  <= i_req_valid && (i_req_target == TARGET_NONE);
			o_ready   <= i_ram_ack || i_periph_ack || none_ack;
			o_bus_err <= none_ack;
		end
	end

	// Unmapped accesses answer with zero
	always_ff @(posedge clock)
	begin
		if (i_ram_ack)
			o_rdata <= i_ram_rdata;
		else if (i_periph_ack)
			o_rdata <= i_periph_rdata;
		else
			o_rdata <= '0;
	end

	a_one_target_ack: assert property (@(posedge clock) disable iff (i_rst)
		!(i_ram_ack && i_periph_ack));

endmodule

`default_nettype wire

// File: rtl/soc_top.sv
`default_nettype none

module soc_top
	import soc_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              i_rst,
	input  wire logic              i_key,
	input  wire logic              i_req,
	input  wire logic              i_rw,
	input  wire logic [DATA_W-1:0] i_addr,
	input  wire logic [DATA_W-1:0] i_wdata,
	output logic                   o_ready,
	output logic [DATA_W-1:0]      o_rdata,
	output logic                   o_bus_err,
	output logic [LED_W-1:0]       o_led,
	output logic                   o_timer_irq
);

	logic              soft_rst;
	logic              sys_rst;

	logic              req_valid;
	target_t           req_target;
	logic              req_rw;
	logic [DATA_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;

	logic              ram_ack;
	logic [DATA_W-1:0] ram_rdata;
	logic              periph_ack;
	logic [DATA_W-1:0] periph_rdata;

	// Key sampler runs on the board reset only
	key_reset_sequencer u_key_reset_sequencer (
		.clock     (clock),
		.i_rst     (i_rst),
		.i_key     (i_key),
		.o_soft_rst(soft_rst)
	);

	assign sys_rst = i_rst || soft_rst;

	// ====================
	// Bus pipeline
	// ====================

	bus_decode_stage u_bus_decode_stage (
		.clock       (clock),
		.i_rst       (sys_rst),
		.i_req       (i_req),
		.i_rw        (i_rw),
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.o_req_valid (req_valid),
		.o_req_target(req_target),
		.o_req_rw    (req_rw),
		.o_req_addr  (req_addr),
		.o_req_wdata (req_wdata)
	);

	block_ram u_block_ram (
		.clock       (clock),
		.i_rst       (sys_rst),
		.i_req_valid (req_valid),
		.i_req_target(req_target),
		.i_req_rw    (req_rw),
		.i_req_addr  (req_addr),
		.i_req_wdata (req_wdata),
		.o_ack       (ram_ack),
		.o_rdata     (ram_rdata)
	);

	led_timer_stage u_led_timer_stage (
		.clock       (clock),
		.i_rst       (sys_rst),
		.i_req_valid (req_valid),
		.i_req_target(req_target),
		.i_req_rw    (req_rw),
		.i_req_addr  (req_addr),
		.i_req_wdata (req_wdata),
		.o_ack       (periph_ack),
		.o_rdata     (periph_rdata),
		.o_led       (o_led),
		.o_timer_irq (o_timer_irq)
	);

	response_stage u_response_stage (
		.clock         (clock),
		.i_rst         (sys_rst),
		.i_req_valid   (req_valid),
		.i_req_target  (req_target),
		.i_ram_ack     (ram_ack),
		.i_ram_rdata   (ram_rdata),
		.i_periph_ack  (periph_ack),
		.i_periph_rdata(periph_rdata),
		.o_ready       (o_ready),
		.o_rdata       (o_rdata),
		.o_bus_err     (o_bus_err)
	);

endmodule

`default_nettype wire

// File: tests/tb_soc.sv
`default_nettype none

module tb_soc
	import soc_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RANDOM     = 300;
	localparam int N_DIRECTED   = 40;
	localparam int WATCHDOG_CYC = (N_RANDOM + N_DIRECTED) * 10 + 2000;
	// Small word range so reads hit earlier writes
	localparam int RAND_WORDS   = 64;

	localparam logic [DATA_W-1:0] LED_ADDR           = {REGION_LED, 28'h0};
	localparam logic [DATA_W-1:0] TIMER_COUNT_ADDR   = {REGION_TIMER, 28'h0};
	localparam logic [DATA_W-1:0] TIMER_COMPARE_ADDR = {REGION_TIMER, 28'h4};

	// Expected response and the edge count at which its ready must show
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              err;
		logic              learn;
		logic [RAM_AW-1:0] idx;
		logic [31:0]       due;
	} expect_t;

	logic              clock = 1'b0;
	logic              i_rst;
	logic              i_key;
	logic              i_req;
	logic              i_rw;
	logic [DATA_W-1:0] i_addr;
	logic [DATA_W-1:0] i_wdata;
	logic              o_ready;
	logic [DATA_W-1:0] o_rdata;
	logic              o_bus_err;
	logic [LED_W-1:0]  o_led;
	logic              o_timer_irq;

	integer            seed = 32'h8ed9;
	logic [31:0]       edge_count = '0;
	expect_t           pending [$];
	logic [DATA_W-1:0] ram_model [RAM_WORDS];
	bit                ram_known [RAM_WORDS];

	soc_top u_soc_top (
		.clock      (clock),
		.i_rst      (i_rst),
		.i_key      (i_key),
		.i_req      (i_req),
		.i_rw       (i_rw),
		.i_addr     (i_addr),
		.i_wdata    (i_wdata),
		.o_ready    (o_ready),
		.o_rdata    (o_rdata),
		.o_bus_err  (o_bus_err),
		.o_led      (o_led),
		.o_timer_irq(o_timer_irq)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
		edge_count <= edge_count + 1'b1;

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("ERR %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// ====================
	// Bus driver
	// ====================

	task automatic send(input logic rw, input logic [DATA_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp_data,
		input logic exp_err, input logic learn);
		expect_t e;
		@(posedge clock);
		i_req   <= 1'b1;
		i_rw    <= rw;
		i_addr  <= addr;
		i_wdata <= wdata;
		e.data  = exp_data;
		e.err   = exp_err;
		e.learn = learn;
		e.idx   = addr[RAM_AW+1:2];
		// Strobe lands on the next edge, ready follows BUS_LATENCY edges later
		e.due   = edge_count + 1 + BUS_LATENCY;
		pending.push_back(e);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clock);
			i_req <= 1'b0;
		end
	endtask

	task automatic drain();
		@(posedge clock);
		i_req <= 1'b0;
		while (pending.size() != 0)
			@(negedge clock);
	endtask

	function automatic logic [DATA_W-1:0] ram_addr(input int idx);
		logic [15:0] upper;
		upper = $random(seed);
		return {REGION_RAM, upper, idx[RAM_AW-1:0], 2'b00};
	endfunction

	task automatic ram_write(input int idx, input logic [DATA_W-1:0] data);
		ram_model[idx] = data;
		ram_known[idx] = 1'b1;
		send(1'b1, ram_addr(idx), data, '0, 1'b0, 1'b0);
	endtask

	// Unwritten words are learned when their first read returns
	task automatic ram_read(input int idx);
		send(1'b0, ram_addr(idx), $random(seed), ram_model[idx], 1'b0, !ram_known[idx]);
	endtask

	// ====================
	// Response checker
	// ====================

	always @(negedge clock)
	begin
		expect_t head;
		if (!i_rst)
		begin
			check_value($isunknown(o_ready), 0, "o_ready is known");
			if (o_ready)
			begin
				check_value(pending.size() > 0, 1, "ready matches an outstanding request");
				head = pending.pop_front();
				check_value(edge_count, head.due, "ready latency in cycles");
				check_value(o_bus_err, head.err, "bus error flag");
				if (head.learn)
				begin
					check_value($isunknown(o_rdata), 0, "unwritten RAM word is known");
					if (!ram_known[head.idx])
					begin
						ram_model[head.idx] = o_rdata;
						ram_known[head.idx] = 1'b1;
					end
				end
				else
					check_value(o_rdata, head.data, "read data");
			end
			else
			begin
				check_value(o_bus_err, 0, "bus error only together with ready");
				if (pending.size() > 0 && pending[0].due <= edge_count)
					check_value(o_ready, 1, "ready at due cycle");
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge clock);
		$display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("ERRORS FOUND");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		logic [31:0]         r;
		logic [REGION_W-1:0] region;
		logic [DATA_W-1:0]   word;
		logic [DATA_W-1:0]   cmp;
		int                  wait_cyc;
		int                  checked;
		i_rst   = 1'b1;
		i_key   = 1'b1;
		i_req   = 1'b0;
		i_rw    = 1'b0;
		i_addr  = '0;
		i_wdata = '0;
		repeat (5) @(posedge clock);
		i_rst <= 1'b0;

		// Mixed RAM, unmapped and LED traffic with gaps of zero to three cycles
		for (int n = 0; n < N_RANDOM; n++)
		begin
			r = $random(seed);
			case (r[2:0])
				3'd0, 3'd1, 3'd2: ram_write(r[13:8], $random(seed));
				3'd3, 3'd4, 3'd5: ram_read(r[13:8]);
				3'd6:
				begin
					region = r[31:28];
					// Flipping bit 1 moves every mapped region to an unmapped one
					if (region == REGION_RAM || region == REGION_LED || region == REGION_TIMER)
						region = region ^ 4'h2;
					send(r[3], {region, r[27:0]}, $random(seed), '0, 1'b1, 1'b0);
				end
				default:
					send(r[3], {REGION_LED, r[27:0]}, $random(seed), '0, 1'b0, 1'b0);
			endcase
			idle(r[5:4]);
		end
		drain();

		// ====================
		// LED and timer
		// ====================

		word = $random(seed) | 32'h1;
		send(1'b1, LED_ADDR, word, '0, 1'b0, 1'b0);
		drain();
		check_value(o_led, word[LED_W-1:0], "LED register after write");
		send(1'b0, LED_ADDR, '1, '0, 1'b0, 1'b0);

		cmp = $random(seed) & 32'h0fff_ffff;
		send(1'b1, TIMER_COMPARE_ADDR, cmp, '0, 1'b0, 1'b0);
		send(1'b0, TIMER_COMPARE_ADDR, '0, cmp, 1'b0, 1'b0);
		send(1'b1, TIMER_COUNT_ADDR, cmp + 32'h1000, '0, 1'b0, 1'b0);
		drain();
		check_value(o_timer_irq, 1, "timer irq with count above compare");
		send(1'b1, TIMER_COMPARE_ADDR, '1, '0, 1'b0, 1'b0);
		drain();
		check_value(o_timer_irq, 0, "timer irq with compare at all ones");

		// ====================
		// Key reset
		// ====================

		send(1'b1, LED_ADDR, 32'hffff_ffff, '0, 1'b0, 1'b0);
		send(1'b1, TIMER_COMPARE_ADDR, 32'h10, '0, 1'b0, 1'b0);
		send(1'b1, TIMER_COUNT_ADDR, 32'h100, '0, 1'b0, 1'b0);
		drain();
		check_value(o_led, {LED_W{1'b1}}, "LED masked before key reset");
		check_value(o_timer_irq, 1, "timer irq before key reset");

		@(posedge clock);
		i_key <= 1'b0;
		repeat (4 * KEY_TICK) @(posedge clock);
		i_key <= 1'b1;
		wait_cyc = 0;
		while ((o_led != '0 || o_timer_irq) && wait_cyc < 8 * KEY_TICK)
		begin
			@(negedge clock);
			wait_cyc++;
		end
		check_value(o_led, '0, "LED cleared by key reset");
		check_value(o_timer_irq, 0, "timer irq cleared by key reset");

		// RAM survives the soft reset
		checked = 0;
		for (int i = 0; i < RAND_WORDS && checked < 8; i++)
		begin
			if (ram_known[i])
			begin
				ram_read(i);
				checked++;
			end
		end
		drain();

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
rtl/soc_pkg.sv
rtl/key_reset_sequencer.sv
rtl/bus_decode_stage.sv
rtl/block_ram.sv
rtl/led_timer_stage.sv
rtl/response_stage.sv
rtl/soc_top.sv
tests/tb_soc.sv

// File: Bender.yml
package:
  name: soc_fabric

sources:
  - rtl/soc_pkg.sv
  - rtl/key_reset_sequencer.sv
  - rtl/bus_decode_stage.sv
  - rtl/block_ram.sv
  - rtl/led_timer_stage.sv
  - rtl/response_stage.sv
  - rtl/soc_top.sv
  - target: test
    files:
      - tests/tb_soc.sv
